/* logic/fe2_pkg.sv */
/*
  Fp2 arithmetic engine types.
  Field element, Fp2 pair, shared add/sub unit request and response,
  and the routing tag that steers responses back to their client.
*/

package fe2_pkg;

  typedef logic [15:0] fe_t;  // One Fp element.

  typedef struct packed {
    fe_t c1;  // Coefficient of u.
    fe_t c0;  // Constant term.
  } fe2_t;

  typedef enum logic {
    FE2_ADD = 1'b0,
    FE2_SUB = 1'b1
  } fe2_op_e;

  typedef enum logic {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } alu_op_e;

  typedef enum logic {
    CL_MNR    = 1'b0,  // Multiply by non-residue.
    CL_ADDSUB = 1'b1   // Fp2 add or subtract.
  } client_e;

  typedef struct packed {
    client_e client;  // Owner of the request.
    logic    comp;    // 0 = c0, 1 = c1.
  } tag_t;

  typedef struct packed {
    fe_t     a;
    fe_t     b;
    alu_op_e op;
    tag_t    tag;
  } alu_req_t;

  typedef struct packed {
    fe_t  res;
    tag_t tag;
  } alu_rsp_t;

  typedef struct packed {
    fe2_t    x;
    fe2_t    y;
    fe2_op_e op;
  } fe2_bin_t;

endpackage

/* logic/fp_add_sub.sv */
/*
  Shared modular add/subtract unit over Fp.
  Two stages: raw sum or difference with carry/borrow, then one
  conditional correction by the modulus. Whole pipe stalls on back-pressure.
*/

module fp_add_sub #(
  parameter fe2_pkg::fe_t P_MOD = 16'd65521
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_req_val,
  output logic               o_req_rdy,
  input  fe2_pkg::alu_req_t  i_req,
  output logic               o_rsp_val,
  input  logic               i_rsp_rdy,
  output fe2_pkg::alu_rsp_t  o_rsp
);

  logic                s1_val;   // Stage 1 holds a raw value.
  logic [16:0]         s1_raw;   // Carry or borrow in bit 16.
  fe2_pkg::alu_op_e    s1_op;
  fe2_pkg::tag_t       s1_tag;
  logic                s2_val;
  fe2_pkg::alu_rsp_t   s2_rsp;
  logic                adv;      // Pipe moves this cycle.
  logic [16:0]         raw_w;
  logic [16:0]         fix_w;

  assign adv       = !(s2_val && !i_rsp_rdy);  // Freeze while output is stuck.
  assign o_req_rdy = adv;
  assign o_rsp_val = s2_val;
  assign o_rsp     = s2_rsp;

  always_comb begin
    if (i_req.op == fe2_pkg::ALU_ADD) begin
      raw_w = {1'b0, i_req.a} + {1'b0, i_req.b};  // Up to 2P - 2.
    end else begin
      raw_w = {1'b0, i_req.a} - {1'b0, i_req.b};  // Bit 16 set on borrow.
    end
  end

  always_comb begin
    fix_w = s1_raw;
    if (s1_op == fe2_pkg::ALU_ADD) begin
      if (s1_raw >= {1'b0, P_MOD}) fix_w = s1_raw - {1'b0, P_MOD};  // Reduce.
    end else if (s1_raw[16]) begin
      fix_w = s1_raw + {1'b0, P_MOD};  // Wraps back below P.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
    end else if (adv) begin
      s1_val <= i_req_val;
      s2_val <= s1_val;
    end
  end

  // Payload path, no reset.
  always_ff @(posedge i_clk) begin
    if (adv) begin
      s1_raw     <= raw_w;
      s1_op      <= i_req.op;
      s1_tag     <= i_req.tag;
      s2_rsp.res <= fix_w[15:0];
      s2_rsp.tag <= s1_tag;
    end
  end

  // Held response must not change until taken.
  a_rsp_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rsp_val && !i_rsp_rdy |=> o_rsp_val && $stable(o_rsp));

endmodule

/* logic/addsub_arbiter.sv */
/*
  Round-robin arbiter for the shared add/sub unit.
  Two request streams in, one out, with the grant locked while stalled.
  Responses go back to the client named in the tag.
*/

module addsub_arbiter #(
  parameter type REQ_T = fe2_pkg::alu_req_t
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_mnr_req_val,
  output logic               o_mnr_req_rdy,
  input  REQ_T               i_mnr_req,
  input  logic               i_bin_req_val,
  output logic               o_bin_req_rdy,
  input  REQ_T               i_bin_req,
  output logic               o_alu_req_val,
  input  logic               i_alu_req_rdy,
  output REQ_T               o_alu_req,
  input  logic               i_alu_rsp_val,
  output logic               o_alu_rsp_rdy,
  input  fe2_pkg::alu_rsp_t  i_alu_rsp,
  output logic               o_mnr_rsp_val,
  input  logic               i_mnr_rsp_rdy,
  output logic               o_bin_rsp_val,
  input  logic               i_bin_rsp_rdy,
  output fe2_pkg::alu_rsp_t  o_rsp
);

  logic rr_bin_pri;  // High when bin goes first on a tie.
  logic lock;        // A granted request is waiting.
  logic lock_bin;    // Which one is waiting.
  logic pick_bin;
  logic gnt_mnr;
  logic gnt_bin;
  logic rsp_to_mnr;

  always_comb begin
    if (lock) begin
      pick_bin = lock_bin;  // Keep the stalled grant.
    end else begin
      pick_bin = i_bin_req_val && (!i_mnr_req_val || rr_bin_pri);
    end
  end

  assign gnt_mnr       = i_mnr_req_val && !pick_bin;
  assign gnt_bin       = i_bin_req_val && pick_bin;
  assign o_alu_req_val = gnt_mnr || gnt_bin;
  assign o_alu_req     = pick_bin ? i_bin_req : i_mnr_req;
  assign o_mnr_req_rdy = gnt_mnr && i_alu_req_rdy;
  assign o_bin_req_rdy = gnt_bin && i_alu_req_rdy;

  // Response demux by tag.
  assign rsp_to_mnr    = (i_alu_rsp.tag.client == fe2_pkg::CL_MNR);
  assign o_mnr_rsp_val = i_alu_rsp_val && rsp_to_mnr;
  assign o_bin_rsp_val = i_alu_rsp_val && !rsp_to_mnr;
  assign o_alu_rsp_rdy = rsp_to_mnr ? i_mnr_rsp_rdy : i_bin_rsp_rdy;
  assign o_rsp         = i_alu_rsp;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rr_bin_pri <= 1'b0;  // CL_MNR first after reset.
      lock       <= 1'b0;
      lock_bin   <= 1'b0;
    end else begin
      if (o_alu_req_val && i_alu_req_rdy) begin
        rr_bin_pri <= !pick_bin;  // Loser goes first next time.
        lock       <= 1'b0;
      end else if (o_alu_req_val) begin
        lock     <= 1'b1;
        lock_bin <= pick_bin;
      end
    end
  end

  // Never two transfers in one cycle.
  a_one_grant: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_mnr_req_val && o_mnr_req_rdy && i_bin_req_val && o_bin_req_rdy));

  // A stalled request keeps its grant and its payload.
  a_grant_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_alu_req_val && !i_alu_req_rdy |=> o_alu_req_val && $stable(o_alu_req));

endmodule

/* logic/fe2_mul_by_nonresidue.sv */
/*
  Fp2 multiply by the non-residue (1 + u).
  c0 = a0 - a1, c1 = a0 + a1, both through the shared add/sub unit.
*/

module fe2_mul_by_nonresidue (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_val,
  output logic               o_rdy,
  input  fe2_pkg::fe2_t      i_dat,
  output logic               o_val,
  input  logic               i_rdy,
  output fe2_pkg::fe2_t      o_dat,
  output logic               o_req_val,
  input  logic               i_req_rdy,
  output fe2_pkg::alu_req_t  o_req,
  input  logic               i_rsp_val,
  input  fe2_pkg::alu_rsp_t  i_rsp
);

  logic          busy;         // One operation in flight.
  logic [1:0]    sent;         // 00, 01, 11 as requests go out.
  logic [1:0]    add_sub_val;  // Result slots filled, by comp.
  fe2_pkg::fe2_t op_a;         // Latched (a0, a1).
  fe2_pkg::fe2_t res;
  logic          in_fire;
  logic          req_fire;
  logic          out_fire;

  assign o_rdy    = !busy;
  assign in_fire  = i_val && o_rdy;
  assign o_val    = &add_sub_val;  // Valid the cycle after the last result.
  assign out_fire = o_val && i_rdy;
  assign o_dat    = res;

  // Second request goes out once comp 0 has been taken.
  assign o_req_val = busy && !sent[1];
  assign req_fire  = o_req_val && i_req_rdy;

  always_comb begin
    o_req.a          = op_a.c0;
    o_req.b          = op_a.c1;
    o_req.tag.client = fe2_pkg::CL_MNR;
    o_req.tag.comp   = sent[0];
    if (sent[0]) begin
      o_req.op = fe2_pkg::ALU_ADD;  // c1 = a0 + a1.
    end else begin
      o_req.op = fe2_pkg::ALU_SUB;  // c0 = a0 - a1.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy        <= 1'b0;
      sent        <= 2'b00;
      add_sub_val <= 2'b00;
    end else begin
      if (in_fire) begin
        busy <= 1'b1;
        sent <= 2'b00;
      end else if (req_fire) begin
        sent <= {sent[0], 1'b1};
      end
      if (i_rsp_val) add_sub_val[i_rsp.tag.comp] <= 1'b1;  // File by comp.
      if (out_fire) begin
        busy        <= 1'b0;
        add_sub_val <= 2'b00;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (in_fire) op_a <= i_dat;
    if (i_rsp_val) begin
      if (i_rsp.tag.comp) res.c1 <= i_rsp.res;
      else res.c0 <= i_rsp.res;
    end
  end

  // Shared unit only answers what this client asked.
  a_no_rsp_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    !busy |-> !i_rsp_val);

endmodule

/* logic/fe2_add_sub.sv */
/*
  Fp2 component-wise add or subtract.
  Two shared operations, c0 first then c1, collected by comp.
*/

module fe2_add_sub (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_val,
  output logic               o_rdy,
  input  fe2_pkg::fe2_bin_t  i_dat,
  output logic               o_val,
  input  logic               i_rdy,
  output fe2_pkg::fe2_t      o_dat,
  output logic               o_req_val,
  input  logic               i_req_rdy,
  output fe2_pkg::alu_req_t  o_req,
  input  logic               i_rsp_val,
  input  fe2_pkg::alu_rsp_t  i_rsp
);

  logic              busy;
  logic              iss_comp;  // Next component to issue.
  logic              iss_done;  // Both requests taken.
  logic [1:0]        got;       // Results in hand.
  fe2_pkg::fe2_bin_t opnd;      // Latched x, y and op.
  fe2_pkg::fe2_t     res;
  fe2_pkg::alu_op_e  alu_op;
  logic              req_fire;

  assign o_rdy     = !busy;
  assign o_val     = got[0] && got[1];
  assign o_dat     = res;
  assign o_req_val = busy && !iss_done;
  assign req_fire  = o_req_val && i_req_rdy;

  always_comb begin
    case (opnd.op)
      fe2_pkg::FE2_SUB: alu_op = fe2_pkg::ALU_SUB;
      default:          alu_op = fe2_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    o_req.op         = alu_op;
    o_req.tag.client = fe2_pkg::CL_ADDSUB;
    o_req.tag.comp   = iss_comp;
    o_req.a          = iss_comp ? opnd.x.c1 : opnd.x.c0;  // Component select.
    o_req.b          = iss_comp ? opnd.y.c1 : opnd.y.c0;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy     <= 1'b0;
      iss_comp <= 1'b0;
      iss_done <= 1'b0;
      got      <= 2'b00;
    end else begin
      if (i_val && o_rdy) begin
        busy     <= 1'b1;  // Start on c0.
        iss_comp <= 1'b0;
        iss_done <= 1'b0;
      end else if (req_fire) begin
        iss_comp <= 1'b1;
        iss_done <= iss_comp;  // Done after c1.
      end
      if (i_rsp_val) got[i_rsp.tag.comp] <= 1'b1;
      if (o_val && i_rdy) begin
        busy <= 1'b0;  // Back to idle on output.
        got  <= 2'b00;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) opnd <= i_dat;
    if (i_rsp_val && !i_rsp.tag.comp) res.c0 <= i_rsp.res;
    if (i_rsp_val && i_rsp.tag.comp) res.c1 <= i_rsp.res;
  end

  // Each component comes back once per operation.
  a_no_dup_rsp: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rsp_val |-> busy && !got[i_rsp.tag.comp]);

endmodule

/* logic/fe2_arith_top.sv */
/*
  Fp2 arithmetic engine top level.
  Multiply-by-non-residue and Fp2 add/sub clients share one
  modular add/sub unit through a round-robin arbiter.
*/

module fe2_arith_top #(
  parameter fe2_pkg::fe_t P_MOD = 16'd65521
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_mnr_val,
  output logic               o_mnr_rdy,
  input  fe2_pkg::fe2_t      i_mnr_dat,
  output logic               o_mnr_val,
  input  logic               i_mnr_rdy,
  output fe2_pkg::fe2_t      o_mnr_dat,
  input  logic               i_bin_val,
  output logic               o_bin_rdy,
  input  fe2_pkg::fe2_bin_t  i_bin_dat,
  output logic               o_bin_val,
  input  logic               i_bin_rdy,
  output fe2_pkg::fe2_t      o_bin_dat
);

  logic              mnr_req_val, mnr_req_rdy;
  fe2_pkg::alu_req_t mnr_req;
  logic              bin_req_val, bin_req_rdy;
  fe2_pkg::alu_req_t bin_req;
  logic              alu_req_val, alu_req_rdy;
  fe2_pkg::alu_req_t alu_req;
  logic              alu_rsp_val, alu_rsp_rdy;
  fe2_pkg::alu_rsp_t alu_rsp;
  logic              mnr_rsp_val, bin_rsp_val;
  fe2_pkg::alu_rsp_t cl_rsp;  // Shared response lines to both clients.

  fe2_mul_by_nonresidue fe2_mul_by_nonresidue_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(i_mnr_val), .o_rdy(o_mnr_rdy), .i_dat(i_mnr_dat),
    .o_val(o_mnr_val), .i_rdy(i_mnr_rdy), .o_dat(o_mnr_dat),
    .o_req_val(mnr_req_val), .i_req_rdy(mnr_req_rdy), .o_req(mnr_req),
    .i_rsp_val(mnr_rsp_val), .i_rsp(cl_rsp)
  );

  fe2_add_sub fe2_add_sub_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(i_bin_val), .o_rdy(o_bin_rdy), .i_dat(i_bin_dat),
    .o_val(o_bin_val), .i_rdy(i_bin_rdy), .o_dat(o_bin_dat),
    .o_req_val(bin_req_val), .i_req_rdy(bin_req_rdy), .o_req(bin_req),
    .i_rsp_val(bin_rsp_val), .i_rsp(cl_rsp)
  );

  // Clients reserve a slot per result, so responses are always taken.
  addsub_arbiter #(.REQ_T(fe2_pkg::alu_req_t)) addsub_arbiter_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_mnr_req_val(mnr_req_val), .o_mnr_req_rdy(mnr_req_rdy), .i_mnr_req(mnr_req),
    .i_bin_req_val(bin_req_val), .o_bin_req_rdy(bin_req_rdy), .i_bin_req(bin_req),
    .o_alu_req_val(alu_req_val), .i_alu_req_rdy(alu_req_rdy), .o_alu_req(alu_req),
    .i_alu_rsp_val(alu_rsp_val), .o_alu_rsp_rdy(alu_rsp_rdy), .i_alu_rsp(alu_rsp),
    .o_mnr_rsp_val(mnr_rsp_val), .i_mnr_rsp_rdy(1'b1),
    .o_bin_rsp_val(bin_rsp_val), .i_bin_rsp_rdy(1'b1),
    .o_rsp(cl_rsp)
  );

  fp_add_sub #(.P_MOD(P_MOD)) fp_add_sub_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_req_val(alu_req_val), .o_req_rdy(alu_req_rdy), .i_req(alu_req),
    .o_rsp_val(alu_rsp_val), .i_rsp_rdy(alu_rsp_rdy), .o_rsp(alu_rsp)
  );

endmodule

/* dv/fe2_arith_tb.sv */
/*
  Self-checking testbench for the Fp2 arithmetic engine.
  A table of operands and expected Fp2 results feeds both client ports at once,
  with random input gaps and random output-ready stalls on each port.
*/

module fe2_arith_tb;

  localparam int N_ROWS     = 12;
  localparam int MAX_CYCLES = 40 * N_ROWS + 200;  // Run limit in clock cycles.

  typedef struct {
    fe2_pkg::client_e client;  // Which port the row goes to.
    fe2_pkg::fe2_op_e op;      // Used by the add/sub port only.
    fe2_pkg::fe2_t    x;       // (a0, a1) for the mnr port.
    fe2_pkg::fe2_t    y;
    fe2_pkg::fe2_t    exp;
  } row_t;

  logic              i_clk;
  logic              i_rst;
  logic              i_mnr_val;
  logic              o_mnr_rdy;
  fe2_pkg::fe2_t     i_mnr_dat;
  logic              o_mnr_val;
  logic              i_mnr_rdy;
  fe2_pkg::fe2_t     o_mnr_dat;
  logic              i_bin_val;
  logic              o_bin_rdy;
  fe2_pkg::fe2_bin_t i_bin_dat;
  logic              o_bin_val;
  logic              i_bin_rdy;
  fe2_pkg::fe2_t     o_bin_dat;

  row_t              rows [N_ROWS];
  fe2_pkg::fe2_t     mnr_in_q[$];
  fe2_pkg::fe2_bin_t bin_in_q[$];
  fe2_pkg::fe2_t     mnr_exp_q[$];   // Expected results, input order.
  fe2_pkg::fe2_t     bin_exp_q[$];
  string             mnr_name_q[$];
  string             bin_name_q[$];
  int                n_mnr;          // Inputs given per port.
  int                n_bin;
  int                mnr_cnt;        // Results taken per port.
  int                bin_cnt;
  int                err_cnt;
  int                cycles;

  fe2_arith_top #(.P_MOD(16'd65521)) fe2_arith_top_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_mnr_val(i_mnr_val), .o_mnr_rdy(o_mnr_rdy), .i_mnr_dat(i_mnr_dat),
    .o_mnr_val(o_mnr_val), .i_mnr_rdy(i_mnr_rdy), .o_mnr_dat(o_mnr_dat),
    .i_bin_val(i_bin_val), .o_bin_rdy(o_bin_rdy), .i_bin_dat(i_bin_dat),
    .o_bin_val(o_bin_val), .i_bin_rdy(i_bin_rdy), .o_bin_dat(o_bin_dat)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;  // Period 8.
  end

  task automatic check_fe2(input string name, input fe2_pkg::fe2_t exp,
                           input fe2_pkg::fe2_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected (c0=%0d, c1=%0d), actual (c0=%0d, c1=%0d)",
               name, exp.c0, exp.c1, act.c0, act.c1);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("Mismatch %s: expected %0d results, actual %0d", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic set_row(input int idx, input fe2_pkg::client_e client,
                         input fe2_pkg::fe2_op_e op,
                         input fe2_pkg::fe_t x0, input fe2_pkg::fe_t x1,
                         input fe2_pkg::fe_t y0, input fe2_pkg::fe_t y1,
                         input fe2_pkg::fe_t e0, input fe2_pkg::fe_t e1);
    rows[idx].client = client;
    rows[idx].op     = op;
    rows[idx].x.c0   = x0;
    rows[idx].x.c1   = x1;
    rows[idx].y.c0   = y0;
    rows[idx].y.c1   = y1;
    rows[idx].exp.c0 = e0;
    rows[idx].exp.c1 = e1;
  endtask

  task automatic feed_mnr();
    int gap;
    while (mnr_in_q.size() > 0) begin
      gap = $urandom_range(0, 2);  // Mostly back to back.
      repeat (gap) @(negedge i_clk);
      i_mnr_dat = mnr_in_q.pop_front();
      i_mnr_val = 1'b1;
      @(posedge i_clk);
      while (!o_mnr_rdy) @(posedge i_clk);  // Hold until taken.
      @(negedge i_clk);
      i_mnr_val = 1'b0;
    end
  endtask

  task automatic feed_bin();
    int gap;
    while (bin_in_q.size() > 0) begin
      gap = $urandom_range(0, 2);
      repeat (gap) @(negedge i_clk);
      i_bin_dat = bin_in_q.pop_front();
      i_bin_val = 1'b1;
      @(posedge i_clk);
      while (!o_bin_rdy) @(posedge i_clk);
      @(negedge i_clk);
      i_bin_val = 1'b0;
    end
  endtask

  task automatic watch_mnr();
    fe2_pkg::fe2_t held;
    logic          stalled;
    stalled = 1'b0;
    forever begin
      @(negedge i_clk);
      i_mnr_rdy = ($urandom_range(0, 3) != 0);  // Stall about one cycle in four.
      @(posedge i_clk);
      if (stalled) begin
        if (!o_mnr_val) begin
          $display("Error: mnr output valid dropped before its transfer");
          err_cnt++;
        end
        check_fe2("mnr held result", held, o_mnr_dat);
      end
      stalled = o_mnr_val && !i_mnr_rdy;
      held    = o_mnr_dat;
      if (o_mnr_val && i_mnr_rdy) begin
        mnr_cnt++;
        if (mnr_exp_q.size() == 0) begin
          $display("Error: mnr port gave a result with no input left to match");
          err_cnt++;
        end else begin
          check_fe2(mnr_name_q.pop_front(), mnr_exp_q.pop_front(), o_mnr_dat);
        end
      end
    end
  endtask

  task automatic watch_bin();
    fe2_pkg::fe2_t held;
    logic          stalled;
    stalled = 1'b0;
    forever begin
      @(negedge i_clk);
      i_bin_rdy = ($urandom_range(0, 3) != 0);
      @(posedge i_clk);
      if (stalled) begin
        if (!o_bin_val) begin
          $display("Error: bin output valid dropped before its transfer");
          err_cnt++;
        end
        check_fe2("bin held result", held, o_bin_dat);
      end
      stalled = o_bin_val && !i_bin_rdy;
      held    = o_bin_dat;
      if (o_bin_val && i_bin_rdy) begin
        bin_cnt++;
        if (bin_exp_q.size() == 0) begin
          $display("Error: bin port gave a result with no input left to match");
          err_cnt++;
        end else begin
          check_fe2(bin_name_q.pop_front(), bin_exp_q.pop_front(), o_bin_dat);
        end
      end
    end
  endtask

  // Run limit.
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    fe2_pkg::fe2_bin_t bin_dat;
    void'($urandom(32'hd225_1b02));
    i_rst     = 1'b1;
    i_mnr_val = 1'b0;
    i_mnr_dat = '0;
    i_mnr_rdy = 1'b1;
    i_bin_val = 1'b0;
    i_bin_dat = '0;
    i_bin_rdy = 1'b1;
    n_mnr     = 0;
    n_bin     = 0;
    mnr_cnt   = 0;
    bin_cnt   = 0;
    err_cnt   = 0;

    // P = 65521.   Port,  op,  x.c0,  x.c1,  y.c0,  y.c1,  then expected c0, c1.
    set_row(0, fe2_pkg::CL_MNR, fe2_pkg::FE2_ADD,  // Plain values.
            16'd100, 16'd30, 16'd0, 16'd0, 16'd70, 16'd130);
    set_row(1, fe2_pkg::CL_ADDSUB, fe2_pkg::FE2_ADD,
            16'd1, 16'd2, 16'd3, 16'd4, 16'd4, 16'd6);
    set_row(2, fe2_pkg::CL_MNR, fe2_pkg::FE2_ADD,  // a0 < a1, borrow.
            16'd5, 16'd20, 16'd0, 16'd0, 16'd65506, 16'd25);
    set_row(3, fe2_pkg::CL_ADDSUB, fe2_pkg::FE2_SUB,  // c1 wraps.
            16'd10, 16'd3, 16'd4, 16'd8, 16'd6, 16'd65516);
    set_row(4, fe2_pkg::CL_MNR, fe2_pkg::FE2_ADD,  // Sum above P.
            16'd60000, 16'd10000, 16'd0, 16'd0, 16'd50000, 16'd4479);
    set_row(5, fe2_pkg::CL_ADDSUB, fe2_pkg::FE2_ADD,  // Sum equals P.
            16'd65520, 16'd0, 16'd1, 16'd0, 16'd0, 16'd0);
    set_row(6, fe2_pkg::CL_MNR, fe2_pkg::FE2_ADD,
            16'd0, 16'd65520, 16'd0, 16'd0, 16'd1, 16'd65520);
    set_row(7, fe2_pkg::CL_ADDSUB, fe2_pkg::FE2_SUB,  // 0 - (P - 1).
            16'd0, 16'd65520, 16'd65520, 16'd0, 16'd1, 16'd65520);
    set_row(8, fe2_pkg::CL_MNR, fe2_pkg::FE2_ADD,  // Both at P - 1.
            16'd65520, 16'd65520, 16'd0, 16'd0, 16'd0, 16'd65519);
    set_row(9, fe2_pkg::CL_ADDSUB, fe2_pkg::FE2_ADD,
            16'd65520, 16'd65520, 16'd65520, 16'd1, 16'd65519, 16'd0);
    set_row(10, fe2_pkg::CL_MNR, fe2_pkg::FE2_ADD,
            16'd1234, 16'd4321, 16'd0, 16'd0, 16'd62434, 16'd5555);
    set_row(11, fe2_pkg::CL_ADDSUB, fe2_pkg::FE2_SUB,
            16'd40000, 16'd7, 16'd40000, 16'd65520, 16'd0, 16'd8);

    for (int i = 0; i < N_ROWS; i++) begin
      if (rows[i].client == fe2_pkg::CL_MNR) begin
        mnr_in_q.push_back(rows[i].x);
        mnr_exp_q.push_back(rows[i].exp);
        mnr_name_q.push_back($sformatf("mnr row %0d", i));
        n_mnr++;
      end else begin
        bin_dat.x  = rows[i].x;
        bin_dat.y  = rows[i].y;
        bin_dat.op = rows[i].op;
        bin_in_q.push_back(bin_dat);
        bin_exp_q.push_back(rows[i].exp);
        bin_name_q.push_back($sformatf("bin row %0d", i));
        n_bin++;
      end
    end

    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;

    // Idle after reset, nothing may come out.
    repeat (8) begin
      @(posedge i_clk);
      if (o_mnr_val || o_bin_val) begin
        $display("Error: output valid high after reset with no input given");
        err_cnt++;
      end
    end
    @(negedge i_clk);

    fork
      watch_mnr();
      watch_bin();
    join_none
    fork
      feed_mnr();
      feed_bin();
    join
    wait (mnr_cnt >= n_mnr && bin_cnt >= n_bin);
    repeat (20) @(negedge i_clk);  // Catch any extra result.

    check_count("mnr result count", n_mnr, mnr_cnt);
    check_count("bin result count", n_bin, bin_cnt);
    $display("Summary: %0d errors, %0d mnr results, %0d bin results",
             err_cnt, mnr_cnt, bin_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
logic/fe2_pkg.sv
logic/fp_add_sub.sv
logic/addsub_arbiter.sv
logic/fe2_mul_by_nonresidue.sv
logic/fe2_add_sub.sv
logic/fe2_arith_top.sv
dv/fe2_arith_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the Fp2 arithmetic testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module fe2_arith_tb \
  -Mdir obj_dir -o fe2_arith_sim > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/fe2_arith_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$SIM_LOG"; then
  echo "Result: fail"
  exit 1
fi
echo "Result: pass"
exit 0
